// File: bench/uart_tb.sv
`timescale 1ns/100ps

module uart_tb import uart_pkg::*; ();

  localparam int clk_period = 100;
  localparam int divisor = 3;
  // start, 8 data, stop
  localparam int frame_clks = 10 * (divisor + 1);
  // every byte written over the whole run
  localparam int total_bytes = 6 + 10 + 5 + 9;
  localparam int watchdog_ns = total_bytes * frame_clks * clk_period * 4 + 100000;
  localparam int poll_limit = 1000;

  // ctrl byte, bit 6 enable, bit 7 low for the low divisor half
  localparam logic [7:0] ctrl_on = {2'b01, 6'(divisor)};
  localparam logic [7:0] ctrl_off = {2'b00, 6'(divisor)};

  // status bit positions, rx flags sit above overrun
  localparam int bit_rx_above = 2;
  localparam int bit_overrun = 0;

  logic clock;
  logic arst_n;
  logic wr_strobe;
  logic rd_strobe;
  logic [addr_w-1:0] addr;
  logic [data_bits-1:0] wdata;
  logic [rdata_w-1:0] rdata;
  logic tx;
  logic irq;

  logic [31:0] rng_state;
  // mirror of the rx fifo contents
  logic [data_bits-1:0] rx_model[$];
  int rx_level;
  int errors;
  int test_errors_start;
  int tests_run;
  int tests_failed;
  string test_name;

  // tx looped straight back into rx
  uart_top dut0 (
    .clock(clock),
    .arst_n(arst_n),
    .wr_strobe(wr_strobe),
    .rd_strobe(rd_strobe),
    .addr(addr),
    .wdata(wdata),
    .rdata(rdata),
    .tx(tx),
    .rx(tx),
    .irq(irq)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #(clk_period / 2) clock = ~clock;
    end
  end

  // four times the serial time of all bytes, plus slack for polling
  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // empty, full, above, below for one fifo
  function automatic logic [3:0] expect_flags(input int count, input int level);
    return {count == 0, count == fifo_depth, count > level, count < level};
  endfunction

  task automatic report_mismatch(input string what, input int expected, input int actual);
    errors++;
    $display("error %s %s: expected %0h actual %0h", test_name, what, expected, actual);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("failure in %s: %s", test_name, what);
  endtask

  // one strobe cycle, driven on the falling edge
  task automatic write_reg(input logic [addr_w-1:0] a, input logic [data_bits-1:0] d);
    @(negedge clock);
    wr_strobe = 1'b1;
    addr = a;
    wdata = d;
    @(negedge clock);
    wr_strobe = 1'b0;
  endtask

  // read mux is combinational, sample mid low phase
  task automatic read_reg(input logic [addr_w-1:0] a, output logic [rdata_w-1:0] d);
    @(negedge clock);
    rd_strobe = 1'b1;
    addr = a;
    #(clk_period / 4);
    d = rdata;
    @(negedge clock);
    rd_strobe = 1'b0;
  endtask

  task automatic send_random(input bit arrives);
    logic [data_bits-1:0] b;
    rng_state = xorshift32(rng_state);
    b = rng_state[data_bits-1:0];
    write_reg(addr_data, b);
    // dropped bytes never reach the model
    if (arrives) begin
      rx_model.push_back(b);
    end
  endtask

  // tx level stays zero, rx level in the upper nibble
  task automatic set_rx_level(input int lvl);
    write_reg(addr_wmark, {cnt_w'(lvl), cnt_w'(0)});
    rx_level = lvl;
  endtask

  task automatic wait_status(input int bit_idx, input string what);
    logic [rdata_w-1:0] s;
    int polls;
    polls = 0;
    s = '0;
    while (!s[bit_idx] && polls < poll_limit) begin
      read_reg(addr_status, s);
      polls++;
    end
    if (!s[bit_idx]) begin
      report_failure({"timed out waiting for ", what});
    end
  endtask

  // above fires once the count passes n-1
  task automatic wait_rx_count(input int n);
    set_rx_level(n - 1);
    wait_status(bit_rx_above, "the rx fifo to fill");
  endtask

  // rx count given by the caller, the model also holds bytes still on the line
  task automatic check_status(input int tx_cnt, input int rx_cnt, input logic ovr,
                              input string what);
    logic [rdata_w-1:0] s;
    logic [rdata_w-1:0] exp;
    exp = {expect_flags(tx_cnt, 0), expect_flags(rx_cnt, rx_level), ovr};
    read_reg(addr_status, s);
    if (s !== exp) begin
      report_mismatch(what, exp, s);
    end
  endtask

  task automatic pop_and_check(input string what);
    logic [rdata_w-1:0] d;
    logic [data_bits-1:0] exp;
    exp = rx_model.pop_front();
    read_reg(addr_data, d);
    if (d !== rdata_w'(exp)) begin
      report_mismatch(what, exp, d);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors_start = errors;
    tests_run++;
  endtask

  task automatic finish_test();
    if (errors == test_errors_start) begin
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - test_errors_start);
    end
  endtask

  initial begin
    logic [rdata_w-1:0] d;
    arst_n = 1'b0;
    wr_strobe = 1'b0;
    rd_strobe = 1'b0;
    addr = '0;
    wdata = '0;
    rng_state = 32'd43;
    rx_level = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    test_name = "none";
    repeat (8) @(negedge clock);
    arst_n = 1'b1;

    start_test("reset");
    if (tx !== 1'b1) begin
      report_mismatch("tx line", 1, tx);
    end
    if (irq !== 1'b0) begin
      report_mismatch("irq", 0, irq);
    end
    check_status(0, 0, 1'b0, "status");
    finish_test();

    start_test("loopback");
    write_reg(addr_ctrl, ctrl_on);
    repeat (6) send_random(1'b1);
    wait_rx_count(6);
    while (rx_model.size() > 0) begin
      pop_and_check("rx byte");
    end
    // nothing left, data read gives zero
    read_reg(addr_data, d);
    if (d !== '0) begin
      report_mismatch("empty fifo read", 0, d);
    end
    finish_test();

    start_test("tx full drop");
    write_reg(addr_ctrl, ctrl_off);
    for (int i = 0; i < 10; i++) begin
      send_random(i < fifo_depth);
    end
    // disabled, so nothing has left the tx fifo yet
    check_status(fifo_depth, 0, 1'b0, "status with tx full");
    write_reg(addr_ctrl, ctrl_on);
    wait_rx_count(fifo_depth);
    while (rx_model.size() > 0) begin
      pop_and_check("rx byte");
    end
    check_status(0, 0, 1'b0, "status after drain");
    finish_test();

    start_test("watermarks");
    repeat (5) send_random(1'b1);
    wait_rx_count(5);
    set_rx_level(3);
    check_status(0, rx_model.size(), 1'b0, "flags before pops");
    while (rx_model.size() > 0) begin
      pop_and_check("rx byte");
      check_status(0, rx_model.size(), 1'b0, "flags after pop");
    end
    finish_test();

    start_test("irq and overrun");
    set_rx_level(2);
    // rx_above only
    write_reg(addr_irq_en, 8'h02);
    if (irq !== 1'b0) begin
      report_mismatch("irq while empty", 0, irq);
    end
    for (int i = 0; i < 9; i++) begin
      send_random(i < fifo_depth);
    end
    wait_status(bit_overrun, "overrun");
    check_status(0, rx_model.size(), 1'b1, "status after overrun");
    if (irq !== (rx_model.size() > rx_level)) begin
      report_mismatch("irq with full fifo", int'(rx_model.size() > rx_level), irq);
    end
    while (rx_model.size() > 0) begin
      pop_and_check("rx byte");
      if (irq !== (rx_model.size() > rx_level)) begin
        report_mismatch("irq after pop", int'(rx_model.size() > rx_level), irq);
      end
    end
    // overrun only, still sticky
    write_reg(addr_irq_en, 8'h01);
    if (irq !== 1'b1) begin
      report_mismatch("irq on overrun", 1, irq);
    end
    write_reg(addr_status, 8'h00);
    if (irq !== 1'b0) begin
      report_mismatch("irq after clear", 0, irq);
    end
    check_status(0, 0, 1'b0, "status after clear");
    finish_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: sim.f
verilog/uart_pkg.sv
verilog/up_down_counter.sv
verilog/wm_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart_top.sv
bench/uart_tb.sv

// File: verilog/uart_pkg.sv
package uart_pkg;

  // byte and fifo geometry
  localparam int data_bits = 8;
  localparam int fifo_depth = 8;
  localparam int ptr_w = 3;
  // one extra bit so the count can reach fifo_depth
  localparam int cnt_w = 4;
  localparam int div_w = 16;
  localparam int addr_w = 3;

  // register map
  localparam logic [addr_w-1:0] addr_data = 3'd0;
  localparam logic [addr_w-1:0] addr_status = 3'd1;
  localparam logic [addr_w-1:0] addr_ctrl = 3'd2;
  localparam logic [addr_w-1:0] addr_wmark = 3'd3;
  localparam logic [addr_w-1:0] addr_irq_en = 3'd4;

  // ctrl write at addr_ctrl, one byte
  // bit 7 picks the half, 0 for divisor[5:0], 1 for divisor[11:6]
  // bit 6 is the enable and is written on every ctrl write
  // bits 5:0 go into the picked divisor half
  // divisor[15:12] stay zero, one bit lasts divisor+1 clocks
  typedef struct packed {
    logic enable;
    logic [div_w-1:0] divisor;
  } uart_ctrl_t;

  // written as one byte, rx level in the upper nibble
  typedef struct packed {
    logic [cnt_w-1:0] rx_level;
    logic [cnt_w-1:0] tx_level;
  } uart_wmark_t;

  typedef struct packed {
    logic empty;
    logic full;
    logic above;
    logic below;
  } fifo_flags_t;

  // status read, overrun in bit 0
  typedef struct packed {
    fifo_flags_t tx;
    fifo_flags_t rx;
    logic overrun;
  } uart_status_t;

  // irq enable, written from wdata[2:0]
  typedef struct packed {
    logic tx_below;
    logic rx_above;
    logic overrun;
  } uart_irq_t;

  // status is the widest read word
  localparam int rdata_w = $bits(uart_status_t);

endpackage

// File: verilog/uart_regs.sv
`timescale 1ns/100ps

module uart_regs import uart_pkg::*; (
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic                 wr_strobe,
  input  logic                 rd_strobe,
  input  logic [addr_w-1:0]    addr,
  input  logic [data_bits-1:0] wdata,
  input  logic [data_bits-1:0] rx_head,
  input  fifo_flags_t          tx_flags,
  input  fifo_flags_t          rx_flags,
  input  logic                 rx_push,
  output logic [rdata_w-1:0]   rdata,
  output logic                 tx_push,
  output logic                 rx_pop,
  output uart_ctrl_t           ctrl,
  output uart_wmark_t          wmark,
  output logic                 irq
);

  uart_irq_t irq_en;
  uart_status_t status;
  logic overrun;

  // full and empty checks live in the fifos
  assign tx_push = wr_strobe & (addr == addr_data);
  assign rx_pop = rd_strobe & (addr == addr_data);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ctrl <= '0;
      wmark <= '0;
      irq_en <= '0;
      overrun <= 1'b0;
    end else begin
      if (wr_strobe && addr == addr_ctrl) begin
        ctrl.enable <= wdata[6];
        // bit 7 picks the divisor half
        if (wdata[7]) begin
          ctrl.divisor[11:6] <= wdata[5:0];
        end else begin
          ctrl.divisor[5:0] <= wdata[5:0];
        end
      end
      if (wr_strobe && addr == addr_wmark) begin
        wmark <= wdata;
      end
      if (wr_strobe && addr == addr_irq_en) begin
        irq_en <= wdata[2:0];
      end
      // sticky until a status write, a new overrun wins
      if (rx_push && rx_flags.full) begin
        overrun <= 1'b1;
      end else if (wr_strobe && addr == addr_status) begin
        overrun <= 1'b0;
      end
    end
  end

  assign status = {tx_flags, rx_flags, overrun};

  // same-cycle read mux
  always_comb begin
    rdata = '0;
    case (addr)
      addr_data: begin
        if (!rx_flags.empty) begin
          rdata = rdata_w'(rx_head);
        end
      end
      addr_status: rdata = status;
      // low divisor half with enable, same layout as the write
      addr_ctrl: rdata = rdata_w'({1'b0, ctrl.enable, ctrl.divisor[5:0]});
      addr_wmark: rdata = rdata_w'(wmark);
      addr_irq_en: rdata = rdata_w'(irq_en);
      default: rdata = '0;
    endcase
  end

  // level irq from masked sources
  assign irq = (irq_en.tx_below & tx_flags.below) |
               (irq_en.rx_above & rx_flags.above) |
               (irq_en.overrun & overrun);

endmodule

// File: verilog/uart_rx.sv
`timescale 1ns/100ps

module uart_rx import uart_pkg::*; (
  input  logic                 clock,
  input  logic                 arst_n,
  input  uart_ctrl_t           ctrl,
  input  logic                 rx,
  output logic                 push,
  output logic [data_bits-1:0] data
);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } rx_state_t;

  rx_state_t state;
  // two sync flops plus one history flop for edge detect
  logic [2:0] rx_sync;
  logic rx_s;
  logic fall;
  logic [div_w-1:0] tick;
  logic [2:0] bit_idx;
  logic [data_bits-1:0] shift;
  logic half_end;
  logic bit_end;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rx_sync <= '1;
    end else begin
      rx_sync <= {rx_sync[1:0], rx};
    end
  end

  assign rx_s = rx_sync[1];
  assign fall = rx_sync[2] & ~rx_s;

  // half bit to land mid start, then full bits
  assign half_end = (tick == (ctrl.divisor >> 1));
  assign bit_end = (tick == ctrl.divisor);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
      tick <= '0;
      bit_idx <= '0;
      push <= 1'b0;
    end else begin
      push <= 1'b0;
      tick <= tick + 1'b1;
      case (state)
        st_idle: begin
          tick <= '0;
          bit_idx <= '0;
          if (ctrl.enable && fall) begin
            state <= st_start;
          end
        end
        st_start: begin
          if (half_end) begin
            tick <= '0;
            // glitch, not a real start bit
            state <= rx_s ? st_idle : st_data;
          end
        end
        st_data: begin
          if (bit_end) begin
            tick <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= st_stop;
            end
          end
        end
        default: begin
          if (bit_end) begin
            // framing error just drops the byte
            push <= rx_s;
            state <= st_idle;
          end
        end
      endcase
      if (!ctrl.enable) begin
        state <= st_idle;
      end
    end
  end

  // bits arrive lsb first
  always_ff @(posedge clock) begin
    if (state == st_data && bit_end) begin
      shift <= {rx_s, shift[data_bits-1:1]};
    end
  end

  // shift holds still in idle, so data is stable with push
  assign data = shift;

endmodule

// File: verilog/uart_top.sv
`timescale 1ns/100ps

module uart_top import uart_pkg::*; (
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic                 wr_strobe,
  input  logic                 rd_strobe,
  input  logic [addr_w-1:0]    addr,
  input  logic [data_bits-1:0] wdata,
  output logic [rdata_w-1:0]   rdata,
  output logic                 tx,
  input  logic                 rx,
  output logic                 irq
);

  uart_ctrl_t ctrl;
  uart_wmark_t wmark;
  fifo_flags_t tx_flags;
  fifo_flags_t rx_flags;
  logic tx_push;
  logic tx_pop;
  logic rx_push;
  logic rx_pop;
  logic [data_bits-1:0] tx_head;
  logic [data_bits-1:0] rx_head;
  logic [data_bits-1:0] rx_byte;

  uart_regs regs0 (
    .clock(clock),
    .arst_n(arst_n),
    .wr_strobe(wr_strobe),
    .rd_strobe(rd_strobe),
    .addr(addr),
    .wdata(wdata),
    .rx_head(rx_head),
    .tx_flags(tx_flags),
    .rx_flags(rx_flags),
    .rx_push(rx_push),
    .rdata(rdata),
    .tx_push(tx_push),
    .rx_pop(rx_pop),
    .ctrl(ctrl),
    .wmark(wmark),
    .irq(irq)
  );

  // bus side pushes, serializer pops
  wm_fifo tx_fifo (
    .clock(clock),
    .arst_n(arst_n),
    .push(tx_push),
    .pop(tx_pop),
    .wdata(wdata),
    .level(wmark.tx_level),
    .rdata(tx_head),
    .flags(tx_flags)
  );

  // deserializer pushes, bus side pops
  wm_fifo rx_fifo (
    .clock(clock),
    .arst_n(arst_n),
    .push(rx_push),
    .pop(rx_pop),
    .wdata(rx_byte),
    .level(wmark.rx_level),
    .rdata(rx_head),
    .flags(rx_flags)
  );

  uart_tx tx0 (
    .clock(clock),
    .arst_n(arst_n),
    .ctrl(ctrl),
    .head(tx_head),
    .fifo_empty(tx_flags.empty),
    .pop(tx_pop),
    .tx(tx)
  );

  uart_rx rx0 (
    .clock(clock),
    .arst_n(arst_n),
    .ctrl(ctrl),
    .rx(rx),
    .push(rx_push),
    .data(rx_byte)
  );

endmodule

// File: verilog/uart_tx.sv
`timescale 1ns/100ps

module uart_tx import uart_pkg::*; (
  input  logic                 clock,
  input  logic                 arst_n,
  input  uart_ctrl_t           ctrl,
  input  logic [data_bits-1:0] head,
  input  logic                 fifo_empty,
  output logic                 pop,
  output logic                 tx
);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } tx_state_t;

  tx_state_t state;
  logic [div_w-1:0] tick;
  logic [2:0] bit_idx;
  logic [data_bits-1:0] shift;
  logic bit_end;

  // last clock of the current bit
  assign bit_end = (tick == ctrl.divisor);

  // take the head in the same cycle a frame starts
  assign pop = (state == st_idle) & ctrl.enable & ~fifo_empty;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
      tick <= '0;
      bit_idx <= '0;
    end else if (!ctrl.enable) begin
      // disabled, drop any frame in flight
      state <= st_idle;
      tick <= '0;
      bit_idx <= '0;
    end else if (state == st_idle) begin
      tick <= '0;
      bit_idx <= '0;
      if (pop) begin
        state <= st_start;
      end
    end else if (!bit_end) begin
      tick <= tick + 1'b1;
    end else begin
      tick <= '0;
      case (state)
        st_start: state <= st_data;
        st_data: begin
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) begin
            state <= st_stop;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // payload shifter, lsb goes out first
  always_ff @(posedge clock) begin
    if (pop) begin
      shift <= head;
    end else if (state == st_data && bit_end) begin
      shift <= shift >> 1;
    end
  end

  // line idles high
  always_comb begin
    case (state)
      st_start: tx = 1'b0;
      st_data: tx = shift[0];
      default: tx = 1'b1;
    endcase
  end

endmodule

// File: verilog/up_down_counter.sv
`timescale 1ns/100ps

module up_down_counter #(
  parameter int width = 4,
  parameter int reset_value = 0
) (
  input  logic             clock,
  input  logic             arst_n,
  input  logic             inc,
  input  logic             dec,
  output logic [width-1:0] value
);

  logic [width-1:0] count;

  // inc and dec together cancel out
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      count <= width'(reset_value);
    end else begin
      case ({inc, dec})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          // hold
          count <= count;
        end
      endcase
    end
  end

  assign value = count;

endmodule

// File: verilog/wm_fifo.sv
`timescale 1ns/100ps

module wm_fifo import uart_pkg::*; (
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic                 push,
  input  logic                 pop,
  input  logic [data_bits-1:0] wdata,
  input  logic [cnt_w-1:0]     level,
  output logic [data_bits-1:0] rdata,
  output fifo_flags_t          flags
);

  logic [data_bits-1:0] mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] fill_cnt;
  logic is_empty;
  logic is_full;
  logic push_ok;
  logic pop_ok;

  // fifo guards itself, callers never check
  assign push_ok = push & ~is_full;
  assign pop_ok = pop & ~is_empty;

  // write pointer, wraps at fifo_depth
  up_down_counter #(
    .width(ptr_w),
    .reset_value(0)
  ) wr_ptr_cnt (
    .clock(clock),
    .arst_n(arst_n),
    .inc(push_ok),
    .dec(1'b0),
    .value(wr_ptr)
  );

  // read pointer points at the head
  up_down_counter #(
    .width(ptr_w),
    .reset_value(0)
  ) rd_ptr_cnt (
    .clock(clock),
    .arst_n(arst_n),
    .inc(pop_ok),
    .dec(1'b0),
    .value(rd_ptr)
  );

  // fill count, up on push, down on pop
  up_down_counter #(
    .width(cnt_w),
    .reset_value(0)
  ) fill_cnt_cnt (
    .clock(clock),
    .arst_n(arst_n),
    .inc(push_ok),
    .dec(pop_ok),
    .value(fill_cnt)
  );

  // storage, no reset needed
  always_ff @(posedge clock) begin
    if (push_ok) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // first word fall-through
  assign rdata = mem[rd_ptr];

  assign is_empty = (fill_cnt == '0);
  assign is_full = (fill_cnt == cnt_w'(fifo_depth));

  // watermark compares are strict
  assign flags.empty = is_empty;
  assign flags.full = is_full;
  assign flags.above = (fill_cnt > level);
  assign flags.below = (fill_cnt < level);

endmodule
